// ==== hdl/combs_cfg.svh ====
`ifndef COMBS_CFG_SVH
`define COMBS_CFG_SVH

`define DATA_WIDTH      34  // Holds 9,999,999,999
`define LONG_DATA_WIDTH 40
`define MAX_DIGITS      10

`endif

// ==== hdl/combs_pkg.sv ====
`include "combs_cfg.svh"

package combs_pkg;

    typedef logic [`DATA_WIDTH-1:0] value_t;
    typedef logic signed [`LONG_DATA_WIDTH-1:0] count_t;
    typedef logic [3:0] digits_t;

    // Minus the Moebius value of k
    function automatic int group_weight(input int k);
        int m;
        int primes;
        m = k;
        primes = 0;
        for (int p = 2; p <= k; p++) begin
            if (m % p == 0) begin
                m = m / p;
                if (m % p == 0)
                    return 0;  // Square factor
                primes++;
            end
        end
        return (primes % 2 == 1) ? 1 : -1;
    endfunction

    function automatic value_t pow10(input int e);
        value_t r;
        r = 1;
        for (int i = 0; i < `MAX_DIGITS; i++) begin
            if (i < e)
                r = r * 10;
        end
        return r;
    endfunction

    // 1, 101, 10101 ... for block length len repeated k times
    function automatic value_t repunit(input int len, input int k);
        value_t r;
        r = '0;
        for (int i = 0; i < `MAX_DIGITS; i++) begin
            if (i < k)
                r = r + pow10(i * len);
        end
        return r;
    endfunction

endpackage

// ==== hdl/get_digs.sv ====
`timescale 1ns/1ps
`include "combs_cfg.svh"

module get_digs
    import combs_pkg::*;
(
    input  value_t  n_in,
    output digits_t digs_out
);

    localparam int N_STEPS = `MAX_DIGITS - 1;

    // Thresholds 10^1 .. 10^9
    function automatic value_t step_value(input int i);
        return pow10(i + 1);
    endfunction

    logic [N_STEPS-1:0] above;

    always_comb begin
        for (int i = 0; i < N_STEPS; i++) begin
            above[i] = (n_in >= step_value(i));
        end
    end

    // Ladder is monotonic, so the highest set step gives the length
    always_comb begin
        digs_out = 4'd1;
        for (int i = 0; i < N_STEPS; i++) begin
            if (above[i])
                digs_out = digits_t'(i + 2);
        end
    end

endmodule

// ==== hdl/block_divider.sv ====
`timescale 1ns/1ps
`include "combs_cfg.svh"

module block_divider
    import combs_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   start,
    input  value_t dividend,
    input  value_t divisor,
    output value_t quotient,
    output logic   done
);

    localparam int ITERS = `DATA_WIDTH;

    logic busy;
    logic [$clog2(ITERS+1)-1:0] iter;

    value_t rem;
    value_t quo;
    value_t div_q;
    logic [`DATA_WIDTH:0] rem_shift;
    logic [`DATA_WIDTH:0] diff;

    assign rem_shift = {rem, quo[`DATA_WIDTH-1]};
    assign diff      = rem_shift - {1'b0, div_q};
    assign quotient  = quo;

    // One quotient bit per cycle, then one cycle to flag done
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            iter <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;  // A running division is dropped
                iter <= '0;
            end else if (busy) begin
                if (iter == ITERS) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    iter <= iter + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            rem   <= '0;
            quo   <= dividend;
            div_q <= divisor;
        end else if (busy && iter != ITERS) begin
            if (rem_shift >= {1'b0, div_q}) begin
                rem <= diff[`DATA_WIDTH-1:0];
                quo <= {quo[`DATA_WIDTH-2:0], 1'b1};
            end else begin
                rem <= rem_shift[`DATA_WIDTH-1:0];
                quo <= {quo[`DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== hdl/group_count.sv ====
`timescale 1ns/1ps

module group_count
    import combs_pkg::*;
#(
    parameter int group_count_n = 2
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    start,
    input  value_t  n_in,
    input  digits_t n_digs_in,
    output logic    group_count_out_valid,
    output count_t  group_count_out
);

    localparam int WEIGHT = group_weight(group_count_n);

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        CHECK,
        HOLD
    } state_t;

    state_t state;

    // Block length and top block divisor, taken straight from the inputs
    digits_t len_in;
    logic    divides_in;
    value_t  divisor_in;

    assign len_in     = digits_t'(n_digs_in / group_count_n);
    assign divides_in = (n_digs_in % group_count_n) == 0;
    assign divisor_in = pow10(n_digs_in - len_in);

    value_t  n_q;
    digits_t len_q;
    logic    divides_q;
    value_t  b_reg;   // Top block
    value_t  quotient;
    logic    div_done;

    block_divider i_block_divider (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .dividend (n_in),
        .divisor  (divisor_in),
        .quotient (quotient),
        .done     (div_done)
    );

    value_t low_v;
    value_t rep_v;
    value_t prod;
    logic   fits;
    count_t raw_count;

    assign low_v = pow10(len_q - 1);
    assign rep_v = repunit(len_q, group_count_n);
    assign prod  = b_reg * rep_v;  // Below 10^d when k divides d
    assign fits  = (prod <= n_q);

    // Blocks from 10^(L-1) up to B, the last only if its repeat fits
    assign raw_count = count_t'(b_reg) - count_t'(low_v) + count_t'(fits);

    always_ff @(posedge clock) begin
        if (reset) begin
            state                 <= IDLE;
            group_count_out_valid <= 1'b0;
        end else if (start) begin
            state                 <= DIVIDE;
            group_count_out_valid <= 1'b0;
        end else begin
            case (state)
                DIVIDE:
                    if (div_done)
                        state <= CHECK;
                CHECK: begin
                    state                 <= HOLD;
                    group_count_out_valid <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            n_q       <= n_in;
            len_q     <= len_in;
            divides_q <= divides_in;
        end
        if (state == DIVIDE && div_done)
            b_reg <= quotient;
        if (state == CHECK) begin
            if (divides_q)
                group_count_out <= raw_count * count_t'(WEIGHT);
            else
                group_count_out <= '0;  // Same latency, nothing to add
        end
    end

endmodule

// ==== hdl/pref_lookup.sv ====
`timescale 1ns/1ps
`include "combs_cfg.svh"

module pref_lookup
    import combs_pkg::*;
(
    input  digits_t idx,
    output count_t  value
);

    typedef count_t table_t [0:`MAX_DIGITS-1];

    // Weighted count of all repeated numbers with exactly d digits
    function automatic count_t length_count(input int d);
        count_t sum;
        sum = '0;
        for (int k = 2; k <= `MAX_DIGITS; k++) begin
            if (k <= d && d % k == 0) begin
                sum = sum + count_t'(group_weight(k)) * count_t'(9)
                    * count_t'(pow10(d / k - 1));
            end
        end
        return sum;
    endfunction

    function automatic table_t build_table();
        table_t t;
        t[0] = '0;
        for (int j = 1; j < `MAX_DIGITS; j++) begin
            t[j] = t[j-1] + length_count(j);
        end
        return t;
    endfunction

    localparam table_t PREF = build_table();

    always_comb begin
        if (idx < `MAX_DIGITS)
            value = PREF[idx];
        else
            value = '0;  // Only reached with no valid input
    end

endmodule

// ==== hdl/count_combs.sv ====
`timescale 1ns/1ps

module count_combs
    import combs_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  value_t n_in,
    input  logic   n_load,
    output logic   count_out_valid,
    output count_t count_out
);

    localparam int N_GROUPS = 6;

    // Repetition counts with a nonzero weight
    localparam int K_LIST [N_GROUPS] = '{2, 3, 5, 6, 7, 10};

    value_t  n_reg;
    logic    start;
    digits_t digs;

    always_ff @(posedge clock) begin
        if (n_load)
            n_reg <= n_in;
    end

    always_ff @(posedge clock) begin
        if (reset)
            start <= 1'b0;
        else
            start <= n_load;
    end

    get_digs i_get_digs (
        .n_in     (n_reg),
        .digs_out (digs)
    );

    count_t gc_out [N_GROUPS];
    logic [N_GROUPS-1:0] gc_valid;

    for (genvar g = 0; g < N_GROUPS; g++) begin : gen_group
        group_count #(
            .group_count_n (K_LIST[g])
        ) i_group_count (
            .clock                 (clock),
            .reset                 (reset),
            .start                 (start),
            .n_in                  (n_reg),
            .n_digs_in             (digs),
            .group_count_out_valid (gc_valid[g]),
            .group_count_out       (gc_out[g])
        );
    end

    count_t stage1 [3];
    count_t stage2 [2];
    count_t stage3;

    // Free running tree, the stage counter says when it holds a result
    always_ff @(posedge clock) begin
        stage1[0] <= gc_out[0] + gc_out[1];  // k = 2, 3
        stage1[1] <= gc_out[2] + gc_out[3];  // k = 5, 6
        stage1[2] <= gc_out[4] + gc_out[5];  // k = 7, 10
        stage2[0] <= stage1[0] + stage1[1];
        stage2[1] <= stage1[2];
        stage3    <= stage2[0] + stage2[1];
    end

    logic [1:0] stage_cnt;

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_cnt <= '0;
        end else if (n_load || start) begin
            stage_cnt <= '0;  // Old result is gone once a load arrives
        end else if (&gc_valid && stage_cnt != 2'd3) begin
            stage_cnt <= stage_cnt + 2'd1;
        end
    end

    assign count_out_valid = (stage_cnt == 2'd3);

    // Shorter lengths
    count_t pref_out;

    pref_lookup i_pref_lookup (
        .idx   (digits_t'(digs - 4'd1)),
        .value (pref_out)
    );

    assign count_out = stage3 + pref_out;

endmodule

// ==== bench/count_combs_checker.sv ====
`timescale 1ns/1ps

module count_combs_checker
    import combs_pkg::*;
(
    input logic   clock,
    input logic   reset,
    input logic   n_load,
    input logic   count_out_valid,
    input count_t count_out
);

    int fail_count = 0;

    valid_low_after_load: assert property (
        @(posedge clock) disable iff (reset)
        n_load |=> !count_out_valid
    ) else begin
        fail_count++;
        $error("count_out_valid still high in the cycle after n_load");
    end

    output_stable: assert property (
        @(posedge clock) disable iff (reset)
        (count_out_valid && $past(count_out_valid)) |-> $stable(count_out)
    ) else begin
        fail_count++;
        $error("count_out changed while count_out_valid stayed high");
    end

    // Rise is seen one edge after the flop sets it, so the load is 42 ticks back
    valid_needs_load: assert property (
        @(posedge clock) disable iff (reset)
        $rose(count_out_valid) |-> $past(n_load, 42)
    ) else begin
        fail_count++;
        $error("count_out_valid rose without an n_load 41 cycles before");
    end

endmodule

// ==== bench/count_combs_tb.sv ====
`timescale 1ns/1ps

module count_combs_tb
    import combs_pkg::*;
();

    localparam int LATENCY = 41;
    localparam int RESULT_TIMEOUT = 100;

    logic   clock;
    logic   reset;
    value_t n_in;
    logic   n_load;
    logic   count_out_valid;
    count_t count_out;

    int          cycle = 0;
    int          load_cycle;
    int          error_count = 0;
    int          test_count = 0;
    int          errors_before;
    bit          timed_out = 1'b0;
    bit          result_seen = 1'b0;
    bit          valid_seen = 1'b0;
    bit          use_brute;
    string       test_name;
    longint      test_n;
    longint      exp_value;
    longint      exp_brute;
    logic [63:0] rng_state = 64'd83;
    logic [63:0] span;
    longint      rand_n;

    count_combs i_count_combs (
        .clock           (clock),
        .reset           (reset),
        .n_in            (n_in),
        .n_load          (n_load),
        .count_out_valid (count_out_valid),
        .count_out       (count_out)
    );

    bind count_combs count_combs_checker i_count_combs_checker (
        .clock           (clock),
        .reset           (reset),
        .n_load          (n_load),
        .count_out_valid (count_out_valid),
        .count_out       (count_out)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    function automatic longint pow10_ref(input int e);
        longint r;
        r = 1;
        for (int i = 0; i < e; i++)
            r = r * 10;
        return r;
    endfunction

    // Minus the Moebius value, from the prime exponents of k
    function automatic int mobius_weight(input int k);
        int m;
        int e;
        int sign;
        m = k;
        sign = 1;
        for (int p = 2; p <= k; p++) begin
            e = 0;
            while (m % p == 0) begin
                m = m / p;
                e++;
            end
            if (e > 1)
                return 0;
            if (e == 1)
                sign = -sign;
        end
        return -sign;
    endfunction

    function automatic longint expected_count(input longint n);
        longint total;
        longint lo;
        longint hi;
        longint rep;
        longint t;
        int     d;
        int     blk;
        d = 1;
        t = n;
        while (t >= 10) begin
            t = t / 10;
            d++;
        end
        total = 0;
        for (int len = 1; len < d; len++) begin
            for (int k = 2; k <= len; k++) begin
                if (len % k == 0)
                    total += mobius_weight(k) * 9 * pow10_ref(len / k - 1);
            end
        end
        for (int k = 2; k <= d; k++) begin
            if (d % k == 0) begin
                blk = d / k;
                rep = 0;
                for (int i = 0; i < k; i++)
                    rep += pow10_ref(i * blk);
                lo = pow10_ref(blk - 1);
                hi = n / rep;  // Largest block whose repeat is at most n
                if (hi > pow10_ref(blk) - 1)
                    hi = pow10_ref(blk) - 1;
                if (hi >= lo)
                    total += mobius_weight(k) * (hi - lo + 1);
            end
        end
        return total;
    endfunction

    function automatic bit is_repeated(input longint x);
        string s;
        int    len;
        bit    same;
        s = $sformatf("%0d", x);
        len = s.len();
        for (int p = 1; p < len; p++) begin
            same = 1'b1;
            for (int i = 0; i < len; i++) begin
                if (s[i] != s[(i + p) % len])
                    same = 1'b0;
            end
            if (same)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic longint brute_tally(input longint n);
        longint c;
        c = 0;
        for (longint v = 1; v <= n; v++) begin
            if (is_repeated(v))
                c++;
        end
        return c;
    endfunction

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_valid_time(input int exp, input int measured);
        if (measured != exp) begin
            $display("MISMATCH count_out_valid latency: got 0x%h expected 0x%h",
                     measured, exp);
            error_count++;
        end
    endtask

    // Compare on the first sample of each valid rise
    always @(negedge clock) begin
        if (count_out_valid && !valid_seen) begin
            errors_before = error_count;
            check_valid_time(LATENCY, cycle - load_cycle);
            check_count("count_out", count_out, count_t'(exp_value));
            if (use_brute)
                check_count("count_out (brute tally)", count_out, count_t'(exp_brute));
            test_count++;
            $display("%-9s n=%0d count=%0d %s", test_name, test_n, count_out,
                     (errors_before == error_count) ? "ok" : "FAILED");
            result_seen = 1'b1;
        end
        valid_seen = count_out_valid;
    end

    task automatic load_value(input longint n);
        @(negedge clock);
        n_in = value_t'(n);
        n_load = 1'b1;
        load_cycle = cycle + 1;  // Cycle count after the load edge
        result_seen = 1'b0;
        @(negedge clock);
        n_load = 1'b0;
        n_in = '0;
    endtask

    task automatic wait_result();
        int waited;
        waited = 0;
        while (!result_seen && waited < RESULT_TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (!result_seen) begin
            $display("Timeout: test %s got no valid result within %0d cycles",
                     test_name, RESULT_TIMEOUT);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(input string name, input longint n, input bit brute);
        if (timed_out)
            return;
        test_name = name;
        test_n = n;
        exp_value = expected_count(n);
        use_brute = brute;
        if (brute)
            exp_brute = brute_tally(n);
        load_value(n);
        wait_result();
    endtask

    // Second load lands 10 cycles after the first
    task automatic run_restart(input longint first, input longint second);
        if (timed_out)
            return;
        test_name = "restart";
        test_n = second;
        exp_value = expected_count(second);
        use_brute = 1'b0;
        load_value(first);
        repeat (8) @(negedge clock);
        load_value(second);
        wait_result();
    endtask

    initial begin
        reset = 1'b1;
        n_load = 1'b0;
        n_in = '0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        repeat (2) @(negedge clock);
        if (count_out_valid !== 1'b0) begin
            $display("count_out_valid is not low after reset before any load");
            error_count++;
        end
        $display("reset     valid low after reset %s",
                 (count_out_valid !== 1'b0) ? "FAILED" : "ok");

        run_test("small", 1, 1'b1);
        run_test("small", 11, 1'b1);
        run_test("small", 99, 1'b1);
        run_test("small", 100, 1'b1);
        run_test("small", 1111, 1'b1);
        run_test("small", 1212, 1'b1);
        run_test("small", 99999, 1'b1);

        run_test("overlap", 111111, 1'b0);
        run_test("overlap", 222222, 1'b0);
        run_test("overlap", 121212, 1'b0);
        run_test("overlap", 1111111111, 1'b0);
        run_test("overlap", 1212121212, 1'b0);

        run_test("boundary", 10, 1'b0);
        for (int d = 1; d <= 10; d++)
            run_test("boundary", pow10_ref(d) - 1, 1'b0);

        for (int i = 0; i < 200; i++) begin
            rng_state = xorshift(rng_state);
            span = pow10_ref(1 + int'(rng_state[63:56] % 10)) - 1;
            rand_n = longint'(rng_state[55:0] % span) + 1;
            run_test("random", rand_n, 1'b0);
        end

        run_restart(64'd5555555555, 64'd46464646);

        error_count += i_count_combs.i_count_combs_checker.fail_count;
        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/combs_pkg.sv
hdl/get_digs.sv
hdl/block_divider.sv
hdl/group_count.sv
hdl/pref_lookup.sv
hdl/count_combs.sv
bench/count_combs_checker.sv
bench/count_combs_tb.sv
